/* flist.f */
+incdir+include
rtl/lcd_pkg.sv
rtl/scan_if.sv
rtl/tile_wr_if.sv
rtl/lcd_timing.sv
rtl/host_write_decoder.sv
rtl/overlay_layer.sv
rtl/layer_compositor.sv
rtl/lcd_overlay_top.sv
verification/lcd_overlay_properties.sv
verification/lcd_overlay_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module lcd_overlay_tb \
	-o lcd_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lcd_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

/* verification/lcd_overlay_tb.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_overlay_tb;
	localparam int W = `LCD_H_ACTIVE;
	localparam int H = `LCD_V_ACTIVE;
	localparam int WIN = `TILE_DIM << `TILE_SCALE_SHIFT;
	localparam int LIMIT = 1200000; // About 7 frames plus margin

	logic pixel_clk;
	logic rst;
	logic host_wr;
	logic [`HOST_ADDR_W-1:0] host_addr;
	logic [15:0] host_data;
	logic [4:0] lcd_r;
	logic [5:0] lcd_g;
	logic [4:0] lcd_b;
	logic lcd_den;
	logic lcd_hsync_n;
	logic lcd_vsync_n;

	logic [15:0] frame_buf [W * H];
	logic [15:0] tiles [`LCD_LAYERS][`TILE_DIM * `TILE_DIM];
	int pos_x [`LCD_LAYERS]; // Live position model
	int pos_y [`LCD_LAYERS];
	int seed = 32'h0fddc82e;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycles = 0;

	logic den_q;
	logic vs_q;
	logic hs_q;
	int col;
	int line;
	int frames_done;
	int vs_falls;
	int den_len;
	int act_lines;
	int hs_period;
	int hs_cyc;
	int hs_low;
	int lo_cnt;
	int hs_in_frame;
	int vs_lines;

	lcd_overlay_top dut_i (.*);

	initial begin
		pixel_clk = 1'b0;
		forever #4 pixel_clk = ~pixel_clk;
	end

	initial begin
		rst = 1'b1; // Pulled low on the first edge
		host_wr = 1'b0;
		host_addr = '0;
		host_data = '0;
		den_q = 1'b0;
		vs_q = 1'b1;
		hs_q = 1'b1;
		for (int l = 0; l < `LCD_LAYERS; l++) begin
			pos_x[l] = W; // Hidden after reset
			pos_y[l] = H;
		end
	end

	always @(posedge pixel_clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Frame capture and raster measurement
	always @(posedge pixel_clk) begin
		den_q <= lcd_den;
		vs_q <= lcd_vsync_n;
		hs_q <= lcd_hsync_n;
		hs_cyc <= hs_cyc + 1;
		lo_cnt <= lcd_hsync_n ? 0 : lo_cnt + 1;
		if (hs_q && !lcd_hsync_n) begin
			hs_period <= hs_cyc;
			hs_cyc <= 1;
			hs_in_frame <= hs_in_frame + 1;
		end
		if (!hs_q && lcd_hsync_n)
			hs_low <= lo_cnt;
		if (vs_q && !lcd_vsync_n) begin
			act_lines <= line;
			line <= 0;
			vs_falls <= vs_falls + 1;
			vs_lines <= hs_in_frame;
			hs_in_frame <= 1; // Both syncs fall together
		end else if (den_q && !lcd_den) begin
			den_len <= col;
			line <= line + 1;
			if (line == H - 1)
				frames_done <= frames_done + 1;
		end
		if (lcd_den) begin
			if (line < H && col < W)
				frame_buf[line * W + col] <= {lcd_r, lcd_g, lcd_b};
			col <= col + 1;
		end else begin
			col <= 0;
		end
	end

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, act, exp);
		end
	endtask

	function automatic logic [15:0] expected_pixel(input int x, input int y);
		logic [15:0] v;
		int a;
		v = 16'(x + y);
		for (int l = 0; l < `LCD_LAYERS; l++) begin
			if (x >= pos_x[l] && x < pos_x[l] + WIN &&
				y >= pos_y[l] && y < pos_y[l] + WIN) begin
				a = ((y - pos_y[l]) / 2) * `TILE_DIM + (x - pos_x[l]) / 2;
				if (tiles[l][a] != `COLOR_KEY)
					v = tiles[l][a];
			end
		end
		return v;
	endfunction

	task automatic check_region(input int x0, input int y0, input int x1, input int y1,
		input int step);
		for (int y = (y0 < 0 ? 0 : y0); y <= y1 && y < H; y += step)
			for (int x = (x0 < 0 ? 0 : x0); x <= x1 && x < W; x += step)
				check($sformatf("lcd_rgb(%0d,%0d)", x, y), frame_buf[y * W + x],
					expected_pixel(x, y));
	endtask

	task automatic host_write(input int layer, input int ofs, input logic [15:0] d);
		@(posedge pixel_clk);
		host_wr <= 1'b1;
		host_addr <= {2'(layer), 11'(ofs)};
		host_data <= d;
	endtask

	task automatic host_idle();
		@(posedge pixel_clk);
		host_wr <= 1'b0;
		repeat (4) @(posedge pixel_clk);
	endtask

	task automatic set_position(input int layer, input int x, input int y);
		host_write(layer, `HOST_OFS_ORIGIN_X, 16'(x));
		host_write(layer, `HOST_OFS_ORIGIN_Y, 16'(y));
		host_idle();
	endtask

	task automatic load_tile(input int layer);
		for (int a = 0; a < `TILE_DIM * `TILE_DIM; a++)
			host_write(layer, a, tiles[layer][a]);
		host_idle();
	endtask

	task automatic next_frame();
		int n;
		n = vs_falls;
		while (vs_falls == n)
			@(posedge pixel_clk);
		n = frames_done;
		while (frames_done == n)
			@(posedge pixel_clk);
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		$display("%s: done, %0d errors", name, errors - err0);
	endtask

	task automatic reset_state();
		int e;
		e = errors;
		@(posedge pixel_clk);
		rst <= 1'b0;
		repeat (8) begin
			@(negedge pixel_clk);
			check("lcd_hsync_n", lcd_hsync_n, 1);
			check("lcd_vsync_n", lcd_vsync_n, 1);
			check("lcd_den", lcd_den, 0);
		end
		@(posedge pixel_clk);
		rst <= 1'b1;
		@(posedge pixel_clk);
		@(negedge pixel_clk);
		check("lcd_hsync_n", lcd_hsync_n, 1);
		check("lcd_vsync_n", lcd_vsync_n, 1);
		check("lcd_den", lcd_den, 0);
		finish_test("reset state", e);
	endtask

	task automatic raster_and_background();
		int e;
		e = errors;
		next_frame();
		check_region(0, 0, W - 1, H - 1, 3);
		next_frame(); // Second vsync edge gives a full vsync period
		check("hsync_period", hs_period, `LCD_H_TOTAL);
		check("hsync_low", hs_low, `LCD_H_SYNC);
		check("vsync_lines", vs_lines, `LCD_V_TOTAL);
		check("den_per_line", den_len, W);
		check("active_lines", act_lines, H);
		finish_test("raster timing and background", e);
	endtask

	task automatic single_layer();
		int e;
		e = errors;
		for (int a = 0; a < `TILE_DIM * `TILE_DIM; a++) begin
			tiles[0][a] = 16'($random(seed));
			if (tiles[0][a] == `COLOR_KEY)
				tiles[0][a] = 16'h0001;
		end
		load_tile(0);
		set_position(0, 100, 50);
		pos_x[0] = 100;
		pos_y[0] = 50;
		next_frame();
		check_region(99, 49, 100 + WIN, 50 + WIN, 1);
		finish_test("single layer placement", e);
	endtask

	task automatic priority_and_key();
		int e;
		e = errors;
		for (int a = 0; a < `TILE_DIM * `TILE_DIM; a++) begin
			tiles[1][a] = 16'($random(seed)) | 16'h0001;
			tiles[2][a] = 16'($random(seed)) | 16'h0001;
			if (a / `TILE_DIM >= 24)
				tiles[1][a] = `COLOR_KEY; // Lower rows see through both
			if (a % `TILE_DIM < 8)
				tiles[2][a] = `COLOR_KEY;
		end
		load_tile(1);
		load_tile(2);
		set_position(1, 200, 100);
		set_position(2, 232, 100);
		pos_x[1] = 200;
		pos_y[1] = 100;
		pos_x[2] = 232;
		pos_y[2] = 100;
		next_frame();
		check_region(198, 98, 232 + WIN, 100 + WIN, 1);
		finish_test("priority and colour key", e);
	endtask

	task automatic shadowed_position();
		int e;
		int n;
		e = errors;
		while (line != 100)
			@(posedge pixel_clk);
		n = frames_done;
		set_position(0, 300, 180);
		while (frames_done == n)
			@(posedge pixel_clk);
		check_region(99, 49, 100 + WIN, 50 + WIN, 2);
		check_region(299, 179, 300 + WIN, 180 + WIN, 2);
		pos_x[0] = 300;
		pos_y[0] = 180;
		next_frame();
		check_region(99, 49, 100 + WIN, 50 + WIN, 2);
		check_region(299, 179, 300 + WIN, 180 + WIN, 1);
		finish_test("shadowed position", e);
	endtask

	initial begin
		#1;
		reset_state();
		raster_and_background();
		single_layer();
		priority_and_key();
		shadowed_position();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

/* verification/lcd_overlay_properties.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_overlay_properties (
	input logic pixel_clk,
	input logic rst,
	input logic [4:0] lcd_r,
	input logic [5:0] lcd_g,
	input logic [4:0] lcd_b,
	input logic lcd_den,
	input logic lcd_hsync_n,
	input logic lcd_vsync_n
);
	int hs_low_cnt;
	logic hs_seen; // First line after reset has a short pulse

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			hs_low_cnt <= 0;
			hs_seen <= 1'b0;
		end else begin
			hs_low_cnt <= lcd_hsync_n ? 0 : hs_low_cnt + 1;
			if (lcd_hsync_n && hs_low_cnt != 0)
				hs_seen <= 1'b1;
		end
	end

	hsync_width: assert property (@(posedge pixel_clk) disable iff (!rst)
		($rose(lcd_hsync_n) && hs_seen) |-> (hs_low_cnt == `LCD_H_SYNC))
		else $error("hsync low width %0d", hs_low_cnt);

	den_outside_vsync: assert property (@(posedge pixel_clk) disable iff (!rst)
		!(lcd_den && !lcd_vsync_n))
		else $error("den high during vsync");

	idle_in_reset: assert property (@(posedge pixel_clk)
		!rst |-> (lcd_hsync_n && lcd_vsync_n && !lcd_den && {lcd_r, lcd_g, lcd_b} == 16'h0))
		else $error("outputs active in reset");
endmodule

bind lcd_overlay_top lcd_overlay_properties u_props (.*);

/* rtl/lcd_overlay_top.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_overlay_top (
	input logic pixel_clk,
	input logic rst,
	input logic host_wr,
	input logic [`HOST_ADDR_W-1:0] host_addr,
	input logic [15:0] host_data,
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b,
	output logic lcd_den,
	output logic lcd_hsync_n,
	output logic lcd_vsync_n
);
	scan_if scan ();
	tile_wr_if layer_wr [`LCD_LAYERS] ();

	logic layer_hit [`LCD_LAYERS];
	lcd_pkg::rgb565_t layer_color [`LCD_LAYERS];

	lcd_timing u_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan      (scan)
	);

	host_write_decoder u_decoder (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.host_wr   (host_wr),
		.host_addr (host_addr),
		.host_data (host_data),
		.layer_wr  (layer_wr)
	);

	for (genvar i = 0; i < `LCD_LAYERS; i++) begin : g_layer
		overlay_layer u_layer (
			.pixel_clk (pixel_clk),
			.rst       (rst),
			.scan      (scan),
			.wr        (layer_wr[i]),
			.hit       (layer_hit[i]),
			.color     (layer_color[i])
		);
	end

	layer_compositor u_compositor (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.scan        (scan),
		.hit         (layer_hit),
		.color       (layer_color),
		.lcd_r       (lcd_r),
		.lcd_g       (lcd_g),
		.lcd_b       (lcd_b),
		.lcd_den     (lcd_den),
		.lcd_hsync_n (lcd_hsync_n),
		.lcd_vsync_n (lcd_vsync_n)
	);
endmodule

/* rtl/layer_compositor.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module layer_compositor (
	input logic pixel_clk,
	input logic rst,
	scan_if.dst scan,
	input logic hit [`LCD_LAYERS],
	input lcd_pkg::rgb565_t color [`LCD_LAYERS],
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b,
	output logic lcd_den,
	output logic lcd_hsync_n,
	output logic lcd_vsync_n
);
	localparam int CW = `LCD_COORD_W;

	logic [CW-1:0] x_d1;
	logic [CW-1:0] y_d1;
	logic active_d1;
	logic hsync_n_d1;
	logic vsync_n_d1;
	lcd_pkg::rgb565_t bg;
	lcd_pkg::rgb565_t pick;

	// Scan bits aligned with the layer results
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			active_d1 <= 1'b0;
			hsync_n_d1 <= 1'b1;
			vsync_n_d1 <= 1'b1;
		end else begin
			active_d1 <= scan.active;
			hsync_n_d1 <= scan.hsync_n;
			vsync_n_d1 <= scan.vsync_n;
		end
	end

	always_ff @(posedge pixel_clk) begin
		x_d1 <= scan.x;
		y_d1 <= scan.y;
	end

	assign bg = lcd_pkg::rgb565_t'(16'(x_d1) + 16'(y_d1)); // Gradient

	// Keyed pixels already cleared hit, so the top opaque layer wins
	always_comb begin
		pick = bg;
		for (int i = 0; i < `LCD_LAYERS; i++) begin
			if (hit[i])
				pick = color[i];
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			{lcd_r, lcd_g, lcd_b} <= '0;
			lcd_den <= 1'b0;
			lcd_hsync_n <= 1'b1;
			lcd_vsync_n <= 1'b1;
		end else begin
			lcd_r <= active_d1 ? pick.r : '0;
			lcd_g <= active_d1 ? pick.g : '0;
			lcd_b <= active_d1 ? pick.b : '0;
			lcd_den <= active_d1;
			lcd_hsync_n <= hsync_n_d1;
			lcd_vsync_n <= vsync_n_d1;
		end
	end
endmodule

/* rtl/overlay_layer.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module overlay_layer (
	input logic pixel_clk,
	input logic rst,
	scan_if.dst scan,
	tile_wr_if.dst wr,
	output logic hit,
	output lcd_pkg::rgb565_t color
);
	localparam int CW = `LCD_COORD_W;
	localparam int WIN = `TILE_DIM << `TILE_SCALE_SHIFT; // Screen pixels per edge
	localparam int IDX_W = $clog2(`TILE_DIM);

	lcd_pkg::rgb565_t tile_ram [`TILE_DIM * `TILE_DIM];

	logic [CW-1:0] pend_x;
	logic [CW-1:0] pend_y;
	logic [CW-1:0] org_x; // Live, used by the scan
	logic [CW-1:0] org_y;
	logic [CW-1:0] dx;
	logic [CW-1:0] dy;
	logic in_win;
	logic [`TILE_ADDR_W-1:0] rd_addr;
	lcd_pkg::rgb565_t rd_pix;

	always_ff @(posedge pixel_clk) begin
		if (wr.wr && wr.target == lcd_pkg::TGT_PIXEL)
			tile_ram[wr.addr] <= lcd_pkg::rgb565_t'(wr.data);
	end

	// Host writes land in pending, live copy swaps at frame start
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pend_x <= CW'(`LCD_H_ACTIVE); // Off screen
			pend_y <= CW'(`LCD_V_ACTIVE);
			org_x <= CW'(`LCD_H_ACTIVE);
			org_y <= CW'(`LCD_V_ACTIVE);
		end else begin
			if (wr.wr && wr.target == lcd_pkg::TGT_ORIGIN_X)
				pend_x <= wr.data[CW-1:0];
			if (wr.wr && wr.target == lcd_pkg::TGT_ORIGIN_Y)
				pend_y <= wr.data[CW-1:0];
			if (scan.frame_start) begin
				org_x <= pend_x;
				org_y <= pend_y;
			end
		end
	end

	assign dx = scan.x - org_x;
	assign dy = scan.y - org_y;
	assign in_win = scan.active &&
		(scan.x >= org_x) && (dx < CW'(WIN)) &&
		(scan.y >= org_y) && (dy < CW'(WIN));

	// Drop the scale bits to get the stored pixel
	assign rd_addr = {dy[`TILE_SCALE_SHIFT +: IDX_W], dx[`TILE_SCALE_SHIFT +: IDX_W]};
	assign rd_pix = tile_ram[rd_addr];

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst)
			hit <= 1'b0;
		else
			hit <= in_win && (rd_pix != lcd_pkg::rgb565_t'(`COLOR_KEY));
	end

	always_ff @(posedge pixel_clk) begin
		color <= rd_pix;
	end
endmodule

/* rtl/host_write_decoder.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module host_write_decoder (
	input logic pixel_clk,
	input logic rst,
	input logic host_wr,
	input logic [`HOST_ADDR_W-1:0] host_addr,
	input logic [15:0] host_data,
	tile_wr_if.src layer_wr [`LCD_LAYERS]
);
	localparam int LAYER_W = $clog2(`LCD_LAYERS);
	localparam int OFS_W = `HOST_ADDR_W - LAYER_W;

	logic [LAYER_W-1:0] layer_sel;
	logic [OFS_W-1:0] offset;
	lcd_pkg::tile_target_e target;

	assign layer_sel = host_addr[`HOST_ADDR_W-1 -: LAYER_W];
	assign offset = host_addr[OFS_W-1:0];

	always_comb begin
		if (offset < OFS_W'(`TILE_DIM * `TILE_DIM))
			target = lcd_pkg::TGT_PIXEL;
		else if (offset == OFS_W'(`HOST_OFS_ORIGIN_X))
			target = lcd_pkg::TGT_ORIGIN_X;
		else if (offset == OFS_W'(`HOST_OFS_ORIGIN_Y))
			target = lcd_pkg::TGT_ORIGIN_Y;
		else
			target = lcd_pkg::TGT_NONE; // Unmapped, dropped
	end

	for (genvar i = 0; i < `LCD_LAYERS; i++) begin : g_lane
		always_ff @(posedge pixel_clk or negedge rst) begin
			if (!rst)
				layer_wr[i].wr <= 1'b0;
			else
				layer_wr[i].wr <= host_wr && (layer_sel == LAYER_W'(i)) &&
					(target != lcd_pkg::TGT_NONE);
		end

		always_ff @(posedge pixel_clk) begin
			layer_wr[i].target <= target;
			layer_wr[i].addr <= offset[`TILE_ADDR_W-1:0];
			layer_wr[i].data <= host_data;
		end
	end
endmodule

/* rtl/lcd_timing.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_timing (
	input logic pixel_clk,
	input logic rst,
	scan_if.src scan
);
	localparam int H_CNT_W = $clog2(`LCD_H_TOTAL);
	localparam int V_CNT_W = $clog2(`LCD_V_TOTAL);
	localparam int H_START = `LCD_H_SYNC + `LCD_H_BACK;
	localparam int V_START = `LCD_V_SYNC + `LCD_V_BACK;

	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic [H_CNT_W-1:0] h_next;
	logic [V_CNT_W-1:0] v_next;
	logic h_in;
	logic v_in;

	// Next count, so the registered outputs line up with the counters
	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_cnt == H_CNT_W'(`LCD_H_TOTAL - 1)) begin
			h_next = '0;
			if (v_cnt == V_CNT_W'(`LCD_V_TOTAL - 1))
				v_next = '0;
			else
				v_next = v_cnt + 1'b1;
		end
	end

	assign h_in = (h_next >= H_CNT_W'(H_START)) &&
		(h_next < H_CNT_W'(H_START + `LCD_H_ACTIVE));
	assign v_in = (v_next >= V_CNT_W'(V_START)) &&
		(v_next < V_CNT_W'(V_START + `LCD_V_ACTIVE));

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
			scan.hsync_n <= 1'b1;
			scan.vsync_n <= 1'b1;
			scan.active <= 1'b0;
			scan.frame_start <= 1'b0;
			scan.x <= '0;
			scan.y <= '0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			scan.hsync_n <= !(h_next < H_CNT_W'(`LCD_H_SYNC));
			scan.vsync_n <= !(v_next < V_CNT_W'(`LCD_V_SYNC));
			scan.active <= h_in && v_in;
			scan.frame_start <= (h_next == '0) && (v_next == '0);
			scan.x <= h_in ? `LCD_COORD_W'(h_next - H_CNT_W'(H_START)) : '0;
			scan.y <= v_in ? `LCD_COORD_W'(v_next - V_CNT_W'(V_START)) : '0;
		end
	end
endmodule

/* rtl/tile_wr_if.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

interface tile_wr_if;
	logic wr; // Beat on every cycle it is high
	lcd_pkg::tile_target_e target;
	logic [`TILE_ADDR_W-1:0] addr;
	logic [15:0] data;

	modport src (
		output wr, target, addr, data
	);

	modport dst (
		input wr, target, addr, data
	);
endinterface

/* rtl/scan_if.sv */
`timescale 1ns/1ps
`include "lcd_defs.svh"

interface scan_if;
	logic [`LCD_COORD_W-1:0] x; // Active area column
	logic [`LCD_COORD_W-1:0] y; // Active area line
	logic active;
	logic hsync_n;
	logic vsync_n;
	logic frame_start; // One cycle at h = 0, v = 0

	modport src (
		output x, y, active, hsync_n, vsync_n, frame_start
	);

	modport dst (
		input x, y, active, hsync_n, vsync_n, frame_start
	);
endinterface

/* rtl/lcd_pkg.sv */
package lcd_pkg;

	// RGB565 pixel as driven on the panel bus
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Decoded destination of one host write
	typedef enum logic [1:0] {
		TGT_PIXEL    = 2'd0,
		TGT_ORIGIN_X = 2'd1,
		TGT_ORIGIN_Y = 2'd2,
		TGT_NONE     = 2'd3
	} tile_target_e;

endpackage

/* include/lcd_defs.svh */
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// Horizontal timing in pixel clocks
`define LCD_H_SYNC    4
`define LCD_H_BACK    39
`define LCD_H_ACTIVE  480
`define LCD_H_FRONT   8
`define LCD_H_TOTAL   (`LCD_H_SYNC + `LCD_H_BACK + `LCD_H_ACTIVE + `LCD_H_FRONT)

// Vertical timing in lines
`define LCD_V_SYNC    4
`define LCD_V_BACK    8
`define LCD_V_ACTIVE  272
`define LCD_V_FRONT   8
`define LCD_V_TOTAL   (`LCD_V_SYNC + `LCD_V_BACK + `LCD_V_ACTIVE + `LCD_V_FRONT)

`define LCD_COORD_W   9
`define LCD_LAYERS    4

`define TILE_DIM          32
`define TILE_SCALE_SHIFT  1  // 2x magnification
`define TILE_ADDR_W       10

`define HOST_ADDR_W        13  // Layer in 12:11, offset in 10:0
`define HOST_OFS_ORIGIN_X  1024
`define HOST_OFS_ORIGIN_Y  1025

`define COLOR_KEY  16'h0000  // Transparent tile pixel

`endif
